//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --assert --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_board_specific_top
FILELIST   = src.f
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- audio_pkg.sv
package audio_pkg;

    localparam int MIC_W = 24;      // INMP441 word length

    typedef struct packed {
        logic               valid;  // One-cycle strobe, no back-pressure
        logic [MIC_W - 1:0] value;  // Two's complement left sample
    } mic_sample_t;

endpackage

//--- board_consts.svh
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// ----------------------------------------------------------------------
// Board clock and serial link dividers

`define CLK_MHZ         25      // Main board oscillator
`define TM_CLK_DIV      4       // Cycles per half TM1638 serial clock
`define MIC_SCK_DIV     4       // Cycles per half I2S sck

// ----------------------------------------------------------------------
// Front panel geometry and key filtering

`define N_DIGITS        8       // 7-segment digits on the panel
`define N_KEYS          8       // Panel keys, two per read byte
`define DEBOUNCE_SCANS  3       // Equal scans needed to accept a new level

`endif

//--- board_specific_top.sv
`timescale 1ns/1ps

`include "board_consts.svh"

module board_specific_top
(
    input  logic clk,
    input  logic rst_n,
    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,
    output logic tm_sio_clk,
    output logic tm_sio_stb,
    inout  wire  tm_sio_data
);

    import audio_pkg::*;
    import board_types_pkg::*;

    mic_sample_t          mic_sample;
    key_scan_t            key_scan;
    tm_display_t          display;
    logic [`N_KEYS - 1:0] keys_stable;

    // ----------------------------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk    ( clk        ),
        .rst_n  ( rst_n      ),
        .sck    ( mic_sck    ),
        .ws     ( mic_ws     ),
        .lr     ( mic_lr     ),
        .sd     ( mic_sd     ),
        .sample ( mic_sample )
    );

    tm1638_board_controller i_tm1638
    (
        .clk      ( clk         ),
        .rst_n    ( rst_n       ),
        .display  ( display     ),
        .keys     ( key_scan    ),
        .sio_clk  ( tm_sio_clk  ),
        .sio_stb  ( tm_sio_stb  ),
        .sio_data ( tm_sio_data )
    );

    generate
        for (genvar i = 0; i < `N_KEYS; i++)
        begin : g_debounce
            key_debouncer i_debouncer
            (
                .clk        ( clk              ),
                .rst_n      ( rst_n            ),
                .scan_valid ( key_scan.valid   ),
                .raw        ( key_scan.raw [i] ),
                .stable     ( keys_stable  [i] )
            );
        end
    endgenerate

    lab_top i_top
    (
        .clk     ( clk         ),
        .rst_n   ( rst_n       ),
        .sample  ( mic_sample  ),
        .keys    ( keys_stable ),
        .display ( display     )
    );

endmodule

//--- board_types_pkg.sv
`include "board_consts.svh"

package board_types_pkg;

    // Segment bytes are hgfedcba, segment a in bit 0
    typedef struct packed {
        logic [`N_DIGITS - 1:0][7:0] seg;   // seg[k] drives digit k
        logic [`N_DIGITS - 1:0]      led;   // One LED per digit position
    } tm_display_t;

    typedef struct packed {
        logic                   valid;      // One-cycle strobe per frame
        logic [`N_KEYS - 1:0]   raw;        // Undebounced key levels
    } key_scan_t;

    // ----------------------------------------------------------------------
    // TM1638 command byte, top two bits select the command class

    localparam logic [1:0] CMD_DATA = 2'b01;
    localparam logic [1:0] CMD_ADDR = 2'b11;
    localparam logic [7:0] DISP_ON_MAX = 8'h8F;    // Display on, full brightness

    typedef struct packed {
        logic [1:0] cls;
        logic [1:0] zero;
        logic       test;       // Test mode, kept low
        logic       fixed;      // Fixed address instead of auto increment
        logic       read;       // Key read instead of display write
        logic       rsvd;
    } tm_data_cmd_t;

    typedef struct packed {
        logic [1:0] cls;
        logic [1:0] zero;
        logic [3:0] addr;       // Start address of the write burst
    } tm_addr_cmd_t;

    typedef union packed {
        tm_data_cmd_t data;
        tm_addr_cmd_t addr;
        logic [7:0]   raw;
    } tm_cmd_u;

endpackage

//--- inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps

`include "board_consts.svh"

module inmp441_mic_i2s_receiver
(
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    input  logic                   sd,
    output audio_pkg::mic_sample_t sample
);

    import audio_pkg::*;

    localparam int DIV_W = $clog2(`MIC_SCK_DIV + 1);

    logic [DIV_W - 1:0] div_cnt;
    logic [5:0]         bit_cnt;        // sck periods in one ws frame
    logic               div_end;
    logic               sck_rise;
    logic               sck_fall;
    logic               take_bit;
    logic [MIC_W - 1:0] shift_q;
    logic               valid_q;

    assign div_end  = div_cnt == DIV_W'(`MIC_SCK_DIV - 1);
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end & sck;

    // Left slot data sits in bits 1 to 24 after ws falls
    assign take_bit = sck_rise & ~ws
                    & (bit_cnt[4:0] >= 5'd1) & (bit_cnt[4:0] <= 5'(MIC_W));

    assign ws = bit_cnt[5];             // Toggles every 32 sck periods
    assign lr = 1'b0;                   // Mic answers in the left slot

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;

            if (div_end)
                sck <= ~sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;

            valid_q <= take_bit & (bit_cnt[4:0] == 5'(MIC_W));    // Last bit in
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_bit)
            shift_q <= {shift_q[MIC_W - 2:0], sd};   // MSB first
    end

    assign sample.valid = valid_q;
    assign sample.value = shift_q;

endmodule

//--- key_debouncer.sv
`timescale 1ns/1ps

`include "board_consts.svh"

module key_debouncer
(
    input  logic clk,
    input  logic rst_n,
    input  logic scan_valid,
    input  logic raw,
    output logic stable
);

    localparam int CNT_W = $clog2(`DEBOUNCE_SCANS + 1);

    logic [CNT_W - 1:0] diff_cnt;       // Consecutive scans against stable

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            stable   <= 1'b0;
            diff_cnt <= '0;
        end
        else if (scan_valid)
        begin
            if (raw == stable)
                diff_cnt <= '0;         // Agreeing scan restarts the count
            else if (diff_cnt == CNT_W'(`DEBOUNCE_SCANS - 1))
            begin
                stable   <= raw;
                diff_cnt <= '0;
            end
            else
                diff_cnt <= diff_cnt + 1'b1;
        end
    end

endmodule

//--- lab_top.sv
`timescale 1ns/1ps

`include "board_consts.svh"

module lab_top
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  audio_pkg::mic_sample_t       sample,
    input  logic [`N_KEYS - 1:0]         keys,
    output board_types_pkg::tm_display_t display
);

    import audio_pkg::*;

    localparam int N_HEX = MIC_W / 4;   // Digits carrying the sample

    logic [MIC_W - 1:0] held;

    function automatic logic [7:0] hex_font(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 8'h3F;
            4'h1:    return 8'h06;
            4'h2:    return 8'h5B;
            4'h3:    return 8'h4F;
            4'h4:    return 8'h66;
            4'h5:    return 8'h6D;
            4'h6:    return 8'h7D;
            4'h7:    return 8'h07;
            4'h8:    return 8'h7F;
            4'h9:    return 8'h6F;
            4'hA:    return 8'h77;
            4'hB:    return 8'h7C;
            4'hC:    return 8'h39;
            4'hD:    return 8'h5E;
            4'hE:    return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            held <= '0;
        else if (sample.valid && !keys[0])  // Key 0 freezes the display
            held <= sample.value;
    end

    always_comb
    begin
        for (int k = 0; k < N_HEX; k++)
            display.seg[k] = hex_font(held[4 * k +: 4]);    // Least significant first
        for (int k = N_HEX; k < `N_DIGITS; k++)
            display.seg[k] = 8'h00;
        display.led = keys;
    end

endmodule

//--- src.f
+incdir+.
audio_pkg.sv
board_types_pkg.sv
inmp441_mic_i2s_receiver.sv
tm1638_board_controller.sv
key_debouncer.sv
lab_top.sv
board_specific_top.sv
tb_board_models.sv
tb_board_specific_top.sv

//--- tb_board_models.sv
`timescale 1ns/1ps

// I2S microphone source, answers the left slot with pseudo random words
module i2s_source
(
    input  logic rst_n,
    input  logic sck,
    output logic sd
);

    logic [31:0] rng       = 32'd24030;     // Fixed seed
    logic [5:0]  cnt       = '0;            // sck falls since reset, mirrors the ws frame
    logic [5:0]  nxt;
    logic [23:0] word      = '0;
    logic [23:0] last_word = '0;            // Last word fully driven on sd
    logic [23:0] prev_word = '0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial sd = 1'b0;

    always @(negedge sck)
    begin
        if (rst_n === 1'b1)
        begin
            nxt = cnt + 6'd1;
            cnt <= nxt;
            if (!nxt[5] && nxt[4:0] == 5'd1)
            begin
                rng  = xorshift(rng);
                word <= rng[23:0];
                sd   <= rng[23];                // MSB first
            end
            else if (!nxt[5] && nxt[4:0] >= 5'd2 && nxt[4:0] <= 5'd24)
            begin
                sd <= word[5'd24 - nxt[4:0]];
                if (nxt[4:0] == 5'd24)
                begin
                    prev_word <= last_word;
                    last_word <= word;
                end
            end
            else
                sd <= 1'b0;
        end
    end

endmodule

// TM1638 panel, records each transfer and answers key reads
module tm1638_panel
(
    input  logic       sio_clk,
    input  logic       sio_stb,
    inout  wire        sio_data,
    input  logic [7:0] key_vec
);

    logic [7:0] rx [0:20];
    logic [7:0] cmd_seen [0:3];
    int         len_seen [0:3];                 // Bits per transfer
    logic [7:0] seg_rx [0:7];
    logic [7:0] led_rx;
    int         nbits     = 0;
    int         xi        = 0;                  // Transfer slot in the frame
    int         frame_cnt = 0;
    logic       drive_en  = 1'b0;
    logic       drive_bit = 1'b0;

    pullup (sio_data);
    assign sio_data = drive_en ? drive_bit : 1'bz;

    // Keys 2r and 2r+1 sit in bits 0 and 4 of read byte r
    function automatic logic key_bit(input int r, input int b);
        if (b == 0)
            return key_vec[2 * r];
        else if (b == 4)
            return key_vec[2 * r + 1];
        return 1'b0;
    endfunction

    always @(posedge sio_clk)
    begin
        if (sio_stb === 1'b0)
        begin
            if (nbits < 168)
                rx[nbits / 8][nbits % 8] = sio_data;    // LSB first
            nbits = nbits + 1;
        end
    end

    always @(negedge sio_clk)
    begin
        if (sio_stb === 1'b0 && nbits >= 8 && rx[0] == 8'h42 && nbits < 40)
        begin
            drive_en  <= 1'b1;
            drive_bit <= key_bit(nbits / 8 - 1, nbits % 8);
        end
    end

    always @(posedge sio_stb)
    begin
        if (nbits > 0)
        begin
            drive_en     <= 1'b0;
            cmd_seen[xi] = rx[0];
            len_seen[xi] = nbits;
            if (rx[0] == 8'hC0 && nbits == 136)
            begin
                for (int k = 0; k < 8; k++)
                begin
                    seg_rx[k]    = rx[1 + 2 * k];
                    led_rx[k]    = rx[2 + 2 * k][0];
                end
            end
            nbits = 0;
            if (xi == 3)
                frame_cnt = frame_cnt + 1;
            xi = (xi + 1) % 4;
        end
    end

endmodule

//--- tb_board_specific_top.sv
`timescale 1ns/1ps

module tb_board_specific_top;

    localparam int FRAME_CYC   = 1568;      // 4 gaps and 24 bytes of 64 cycles
    localparam int TEST_FRAMES = 27;
    localparam int LIMIT       = (TEST_FRAMES + 5) * FRAME_CYC;

    logic       clk;
    logic       rst_n;
    logic       mic_sck, mic_ws, mic_lr, mic_sd;
    logic       tm_sio_clk, tm_sio_stb;
    wire        tm_sio_data;
    logic [7:0] key_vec;

    int         cycles      = 0;
    int         frames_seen = 0;
    int         freeze_pairs = 0;
    logic       short_seen  = 1'b0;
    logic       long_seen   = 1'b0;
    logic       led0_q      = 1'b0;
    logic       stb_q       = 1'b1;
    logic [23:0] cand_a     = '0;           // Source words at frame start
    logic [23:0] cand_b     = '0;
    logic [7:0] seg_q [0:7];

    board_specific_top UUT
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      ),
        .mic_sd      ( mic_sd      ),
        .tm_sio_clk  ( tm_sio_clk  ),
        .tm_sio_stb  ( tm_sio_stb  ),
        .tm_sio_data ( tm_sio_data )
    );

    i2s_source u_source ( .rst_n ( rst_n ), .sck ( mic_sck ), .sd ( mic_sd ) );

    tm1638_panel u_panel
    (
        .sio_clk  ( tm_sio_clk  ),
        .sio_stb  ( tm_sio_stb  ),
        .sio_data ( tm_sio_data ),
        .key_vec  ( key_vec     )
    );

    // ----------------------------------------------------------------------
    // Checking helpers

    task automatic fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        logic [7:0] font [0:15];
        font = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                 8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        return font[n];
    endfunction

    function automatic logic digits_match(input logic [23:0] w);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 6; k++)
            if (u_panel.seg_rx[k] !== seg_pattern(w[4 * k +: 4]))
                ok = 1'b0;
        return ok;
    endfunction

    function automatic logic digits_unchanged();
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 6; k++)
            if (u_panel.seg_rx[k] !== seg_q[k])
                ok = 1'b0;
        return ok;
    endfunction

    task automatic check_frame();
        logic [7:0] led;
        led = u_panel.led_rx;
        assert (u_panel.cmd_seen[0] == 8'h40 && u_panel.cmd_seen[1] == 8'hC0
                && u_panel.cmd_seen[2] == 8'h8F && u_panel.cmd_seen[3] == 8'h42)
            else fail("frame command bytes out of order");
        assert (u_panel.len_seen[0] == 8 && u_panel.len_seen[1] == 136
                && u_panel.len_seen[2] == 8 && u_panel.len_seen[3] == 40)
            else fail("frame transfer lengths wrong");
        assert (u_panel.seg_rx[6] == 8'h00 && u_panel.seg_rx[7] == 8'h00)
            else fail("digits 6 and 7 not blank");
        if (led[3])
            short_seen = 1'b1;
        if (led[5])
            long_seen = 1'b1;
        if (!led[0] && !led0_q)
        begin
            assert (digits_match(cand_a) || digits_match(cand_b))
                else fail("digits do not show a recent sample");
        end
        if (led[0] && led0_q)
        begin
            assert (digits_unchanged()) else fail("digits moved while frozen");
            freeze_pairs++;
        end
        led0_q = led[0];
        for (int k = 0; k < 8; k++)
            seg_q[k] = u_panel.seg_rx[k];
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = u_panel.frame_cnt + n;
        while (u_panel.frame_cnt < target)
            @(posedge clk);
        #2;
    endtask

    // ----------------------------------------------------------------------
    // Clock, timeout and frame monitor

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
        if (!tm_sio_stb && stb_q && u_panel.xi == 0)
        begin
            cand_a = u_source.last_word;
            cand_b = u_source.prev_word;
        end
        stb_q = tm_sio_stb;
        if (u_panel.frame_cnt != frames_seen)
        begin
            frames_seen = u_panel.frame_cnt;
            check_frame();
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus

    initial
    begin
        rst_n   = 1'b0;
        key_vec = 8'h00;
        for (int i = 0; i < 4; i++)
        begin
            @(posedge clk);
            if (i > 0)
            begin
                assert (tm_sio_stb === 1'b1 && tm_sio_clk === 1'b1 && tm_sio_data === 1'b1
                        && mic_sck === 1'b0 && mic_ws === 1'b0 && mic_lr === 1'b0)
                    else fail("pins not idle during reset");
            end
        end
        #2 rst_n = 1'b1;
        @(posedge clk);
        assert (tm_sio_stb === 1'b1 && tm_sio_clk === 1'b1 && tm_sio_data === 1'b1
                && mic_sck === 1'b0 && mic_ws === 1'b0 && mic_lr === 1'b0)
            else fail("pins not idle after reset");

        wait_frames(2);

        key_vec[3] = 1'b1;                  // Short press one scan too few for the debouncer
        wait_frames(2);
        key_vec[3] = 1'b0;
        wait_frames(3);
        assert (!short_seen) else fail("short press of key 3 reached the LEDs");

        key_vec[5] = 1'b1;
        wait_frames(5);
        key_vec[5] = 1'b0;
        wait_frames(3);
        assert (long_seen) else fail("held key 5 never reached the LEDs");

        key_vec[0] = 1'b1;                  // Freeze the display
        wait_frames(6);
        key_vec[0] = 1'b0;
        wait_frames(6);                     // Release settles, then digits follow again
        assert (freeze_pairs >= 2) else fail("freeze key never held the display");

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tm1638_board_controller.sv
`timescale 1ns/1ps

`include "board_consts.svh"

module tm1638_board_controller
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  board_types_pkg::tm_display_t display,
    output board_types_pkg::key_scan_t   keys,
    output logic                         sio_clk,
    output logic                         sio_stb,
    inout  wire                          sio_data
);

    import board_types_pkg::*;

    localparam int HALF    = `TM_CLK_DIV;
    localparam int BIT_CYC = 2 * `TM_CLK_DIV;
    localparam int DIV_W   = $clog2(BIT_CYC);

    typedef enum logic
    {
        S_GAP,                          // Strobe high between transfers
        S_XFER                          // Strobe low, bytes shifting
    } state_t;

    state_t             state;
    logic [1:0]         xfer_idx;       // 0 mode, 1 write, 2 control, 3 read
    logic [4:0]         byte_idx;       // 0 is the command byte
    logic [2:0]         bit_idx;
    logic [DIV_W - 1:0] div_cnt;
    logic               div_end;
    logic [4:0]         last_byte;
    logic [4:0]         slot;
    logic               read_phase;
    logic               sample_pt;
    logic               data_oe;
    logic [7:0]         tx_byte;
    tm_cmd_u            cmd;
    tm_display_t        disp_q;
    logic [`N_KEYS - 1:0] key_raw;
    logic               key_valid;

    assign div_end    = div_cnt == DIV_W'(BIT_CYC - 1);
    assign slot       = byte_idx - 5'd1;
    assign read_phase = (state == S_XFER) && (xfer_idx == 2'd3) && (byte_idx != 5'd0);
    assign sample_pt  = (state == S_XFER) && (div_cnt == DIV_W'(HALF - 1));

    // ----------------------------------------------------------------------
    // Transfer contents

    always_comb
    begin
        cmd = '0;
        case (xfer_idx)
            2'd0:
            begin
                cmd.data.cls  = CMD_DATA;   // Write, auto increment
                cmd.data.read = 1'b0;
            end
            2'd1:
            begin
                cmd.addr.cls  = CMD_ADDR;
                cmd.addr.addr = 4'd0;       // Burst starts at digit 0
            end
            2'd2:    cmd.raw = DISP_ON_MAX;
            default:
            begin
                cmd.data.cls  = CMD_DATA;
                cmd.data.read = 1'b1;       // Key scan read
            end
        endcase
    end

    always_comb
    begin
        case (xfer_idx)
            2'd1:    last_byte = 5'(2 * `N_DIGITS);
            2'd3:    last_byte = 5'(`N_KEYS / 2);
            default: last_byte = 5'd0;
        endcase
    end

    // Segment byte then LED byte for each digit address
    always_comb
    begin
        if (byte_idx == 5'd0)
            tx_byte = cmd.raw;
        else if (slot[0])
            tx_byte = {7'd0, disp_q.led[slot[3:1]]};
        else
            tx_byte = disp_q.seg[slot[3:1]];
    end

    // ----------------------------------------------------------------------
    // Frame sequencer

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= S_GAP;
            xfer_idx  <= 2'd0;
            byte_idx  <= 5'd0;
            bit_idx   <= 3'd0;
            div_cnt   <= '0;
            key_valid <= 1'b0;
        end
        else
        begin
            div_cnt   <= div_end ? '0 : div_cnt + 1'b1;
            key_valid <= 1'b0;

            case (state)
                S_GAP:
                    if (div_end)
                        state <= S_XFER;
                default:
                    if (div_end)
                    begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                        begin
                            if (byte_idx == last_byte)
                            begin
                                byte_idx  <= 5'd0;
                                state     <= S_GAP;
                                xfer_idx  <= xfer_idx + 2'd1;     // Wraps to next frame
                                key_valid <= xfer_idx == 2'd3;
                            end
                            else
                                byte_idx <= byte_idx + 5'd1;
                        end
                    end
            endcase
        end
    end

    // Display snapshot so one frame never mixes two displays
    always_ff @(posedge clk)
    begin
        if (state == S_GAP && div_end && xfer_idx == 2'd0)
            disp_q <= display;
    end

    // Keys 2r and 2r+1 come in bits 0 and 4 of read byte r
    always_ff @(posedge clk)
    begin
        if (read_phase && sample_pt)
        begin
            if (bit_idx == 3'd0)
                key_raw[{slot[1:0], 1'b0}] <= sio_data;
            if (bit_idx == 3'd4)
                key_raw[{slot[1:0], 1'b1}] <= sio_data;
        end
    end

    // ----------------------------------------------------------------------
    // Pins

    assign data_oe  = (state == S_XFER) && !read_phase;
    assign sio_stb  = state == S_GAP;
    assign sio_clk  = (state == S_GAP) || (div_cnt >= DIV_W'(HALF));    // Low half first
    assign sio_data = data_oe ? tx_byte[bit_idx] : 1'bz;               // LSB first

    assign keys.valid = key_valid;
    assign keys.raw   = key_raw;

endmodule
